/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_cpu
FILELIST   := tb.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* alu.sv */
`default_nettype none
`timescale 1ns/1ps

`include "cpu_defs.svh"

module alu
(
    input  cpu_pkg::instr_t      instr,
    input  cpu_pkg::word_t       rd_a,
    input  cpu_pkg::word_t       rd_b,
    input  logic                 flag_a,
    input  logic                 exec,
    output cpu_pkg::rf_write_t   wr,
    output logic                 store_we,
    output cpu_pkg::addr_t       store_addr,
    output cpu_pkg::word_t       store_data,
    output logic                 branch_taken
);

    import cpu_pkg::*;

    // one extra bit catches carry out and borrow
    logic [`CPU_WORD_W:0] sum;
    logic [`CPU_WORD_W:0] diff;
    word_t                result;
    logic                 res_flag;
    logic                 reg_we;
    logic                 flag_we;
    logic                 do_store;

    assign sum  = {1'b0, rd_a} + {1'b0, rd_b};
    assign diff = {1'b0, rd_a} - {1'b0, rd_b};

    always_comb
    begin
        result   = rd_a;
        res_flag = 1'b0;
        reg_we   = 1'b0;
        flag_we  = 1'b0;
        do_store = 1'b0;
        case (instr.opcode)
            `CPU_OP_ADD:
            begin
                result   = sum[`CPU_WORD_W-1:0];
                res_flag = sum[`CPU_WORD_W];
                reg_we   = 1'b1;
                flag_we  = 1'b1;
            end
            `CPU_OP_SUB:
            begin
                result   = diff[`CPU_WORD_W-1:0];
                res_flag = diff[`CPU_WORD_W];
                reg_we   = 1'b1;
                flag_we  = 1'b1;
            end
            `CPU_OP_AND, `CPU_OP_OR, `CPU_OP_XOR:
            begin
                if (instr.opcode == `CPU_OP_AND)
                    result = rd_a & rd_b;
                else if (instr.opcode == `CPU_OP_OR)
                    result = rd_a | rd_b;
                else
                    result = rd_a ^ rd_b;
                res_flag = (result == '0);
                reg_we   = 1'b1;
                flag_we  = 1'b1;
            end
            `CPU_OP_LOADI:
            begin
                // rd_a reads the destination here, see decode in the sequencer
                if (instr.half)
                    result = {instr.imm, rd_a[$bits(imm_t)-1:0]};
                else
                    result = {rd_a[`CPU_WORD_W-1:$bits(imm_t)], instr.imm};
                reg_we  = 1'b1;
                flag_we = 1'b1;
            end
            `CPU_OP_CMP:
            begin
                res_flag = (rd_a < rd_b);
                flag_we  = 1'b1;
            end
            `CPU_OP_STORE:
            begin
                do_store = 1'b1;
            end
            default:
            begin
            end
        endcase
    end

    assign wr = '{reg_we: reg_we && exec, flag_we: flag_we && exec, dst: instr.dst,
                  data: result, flag: res_flag};

    assign store_we   = do_store && exec;
    assign store_addr = rd_a;
    assign store_data = rd_b;

    assign branch_taken = (instr.opcode == `CPU_OP_BRF) && flag_a;

    // exec falls at the end of every execute cycle, so this samples the live strobes
    // a store leaves the registers alone and puts a known address and word on the bus
    a_store_or_write: assert property (
        @(negedge exec) store_we |-> !wr.reg_we && !$isunknown({store_addr, store_data})
    ) else $error("store with a register write or an unknown address or data");

endmodule

`default_nettype wire

/* cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data path and address width
`define CPU_WORD_W    32

// general registers, each with its own flag
`define CPU_NREGS     8

// program counter after reset
`define CPU_RESET_PC  0

// opcodes, anything else is a no-op
`define CPU_OP_ADD    6'd1
`define CPU_OP_SUB    6'd2
`define CPU_OP_AND    6'd3
`define CPU_OP_OR     6'd4
`define CPU_OP_XOR    6'd5
`define CPU_OP_LOADI  6'd6
`define CPU_OP_STORE  6'd7
`define CPU_OP_CMP    6'd8
`define CPU_OP_BRF    6'd9

`endif

/* cpu_pkg.sv */
`default_nettype none

`include "cpu_defs.svh"

package cpu_pkg;

    typedef logic [`CPU_WORD_W-1:0] word_t;
    typedef logic [`CPU_WORD_W-1:0] addr_t;
    typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;
    typedef logic [5:0] opcode_t;
    typedef logic [15:0] imm_t;

    typedef enum logic [1:0]
    {
        FETCH,
        EXECUTE,
        UPDATE
    } cpu_state_t;

    // same bit order as the instruction word, imm on top
    typedef struct packed
    {
        imm_t     imm;
        logic     half;
        reg_idx_t dst;
        reg_idx_t src_b;
        reg_idx_t src_a;
        opcode_t  opcode;
    } instr_t;

    // one register file write, data and flag enabled separately
    typedef struct packed
    {
        logic     reg_we;
        logic     flag_we;
        reg_idx_t dst;
        word_t    data;
        logic     flag;
    } rf_write_t;

endpackage

`default_nettype wire

/* cpu_top.sv */
`default_nettype none
`timescale 1ns/1ps

module cpu_top
(
    input  logic              clock,
    input  logic              rst_n,
    input  cpu_pkg::word_t    mem_rdata,
    output cpu_pkg::addr_t    mem_addr,
    output cpu_pkg::word_t    mem_wdata,
    output logic              mem_we,
    output logic              fetch
);

    import cpu_pkg::*;

    instr_t    instr;
    logic      exec;
    addr_t     pc;
    word_t     rd_a;
    word_t     rd_b;
    logic      flag_a;
    rf_write_t wr;
    logic      store_we;
    addr_t     store_addr;
    word_t     store_data;
    logic      branch_taken;

    sequencer u_sequencer
    (
        .clock        (clock),
        .rst_n        (rst_n),
        .mem_rdata    (mem_rdata),
        .branch_taken (branch_taken),
        .instr        (instr),
        .exec         (exec),
        .fetch        (fetch),
        .pc           (pc)
    );

    reg_file u_reg_file
    (
        .clock    (clock),
        .rst_n    (rst_n),
        .rd_sel_a (instr.src_a),
        .rd_sel_b (instr.src_b),
        .rd_a     (rd_a),
        .rd_b     (rd_b),
        .flag_a   (flag_a),
        .wr       (wr)
    );

    alu u_alu
    (
        .instr        (instr),
        .rd_a         (rd_a),
        .rd_b         (rd_b),
        .flag_a       (flag_a),
        .exec         (exec),
        .wr           (wr),
        .store_we     (store_we),
        .store_addr   (store_addr),
        .store_data   (store_data),
        .branch_taken (branch_taken)
    );

    // the bus carries the store address only while the strobe is up
    assign mem_addr  = store_we ? store_addr : pc;
    assign mem_wdata = store_data;
    assign mem_we    = store_we;

endmodule

`default_nettype wire

/* reg_file.sv */
`default_nettype none
`timescale 1ns/1ps

module reg_file
(
    input  logic                 clock,
    input  logic                 rst_n,
    input  cpu_pkg::reg_idx_t    rd_sel_a,
    input  cpu_pkg::reg_idx_t    rd_sel_b,
    output cpu_pkg::word_t       rd_a,
    output cpu_pkg::word_t       rd_b,
    output logic                 flag_a,
    input  cpu_pkg::rf_write_t   wr
);

    import cpu_pkg::*;

    // one entry per value of the select field
    word_t                               regs [1 << $bits(reg_idx_t)];
    logic  [(1 << $bits(reg_idx_t))-1:0] flags;

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < (1 << $bits(reg_idx_t)); i++)
            begin
                regs[i] <= '0;
            end
            flags <= '0;
        end
        else
        begin
            if (wr.reg_we)
            begin
                regs[wr.dst] <= wr.data;
            end
            if (wr.flag_we)
            begin
                flags[wr.dst] <= wr.flag;
            end
        end
    end

    // reads see the old value until the write edge
    assign rd_a   = regs[rd_sel_a];
    assign rd_b   = regs[rd_sel_b];
    assign flag_a = flags[rd_sel_a];

    // enables come out of the ALU decode and must be clean once out of reset
    a_we_known: assert property (
        @(posedge clock) disable iff (!rst_n)
        !$isunknown({wr.reg_we, wr.flag_we})
    ) else $error("register file write enable is unknown");

endmodule

`default_nettype wire

/* sequencer.sv */
`default_nettype none
`timescale 1ns/1ps

`include "cpu_defs.svh"

module sequencer
(
    input  logic              clock,
    input  logic              rst_n,
    input  cpu_pkg::word_t    mem_rdata,
    input  logic              branch_taken,
    output cpu_pkg::instr_t   instr,
    output logic              exec,
    output logic              fetch,
    output cpu_pkg::addr_t    pc
);

    import cpu_pkg::*;

    cpu_state_t state;
    instr_t     ir;
    logic       branch_q;
    addr_t      pc_next;

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= FETCH;
            pc       <= addr_t'(`CPU_RESET_PC);
            ir       <= '0;
            branch_q <= 1'b0;
        end
        else
        begin
            case (state)
                FETCH:
                begin
                    ir    <= instr_t'(mem_rdata);
                    state <= EXECUTE;
                end
                EXECUTE:
                begin
                    branch_q <= branch_taken;
                    state    <= UPDATE;
                end
                default:
                begin
                    pc    <= pc_next;
                    state <= FETCH;
                end
            endcase
        end
    end

    // target is the immediate, zero extended
    always_comb
    begin
        pc_next = pc + addr_t'(1);
        if (branch_q)
        begin
            pc_next = addr_t'(ir.imm);
        end
    end

    // LOADI keeps half of its destination, so route dst onto the first read port
    always_comb
    begin
        instr = ir;
        if (ir.opcode == `CPU_OP_LOADI)
        begin
            instr.src_a = ir.dst;
        end
    end

    assign fetch = (state == FETCH);
    assign exec  = (state == EXECUTE);

    // one fetch, one execute, one update, then the next fetch
    a_three_cycles: assert property (
        @(posedge clock) disable iff (!rst_n)
        fetch |-> !exec ##1 (exec && !fetch) ##1 (!exec && !fetch) ##1 fetch
    ) else $error("fetch and execute out of sequence");

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
cpu_pkg.sv
reg_file.sv
alu.sv
sequencer.sv
cpu_top.sv
tb_cpu.sv

/* tb_cpu.sv */
`default_nettype none
`timescale 1ns/1ps

`include "cpu_defs.svh"

module tb_cpu;

    import cpu_pkg::*;

    localparam int CLK_PERIOD_NS = 4;
    localparam int RESET_CYCLES  = 10;
    localparam int NUM_INSTR     = 600;
    localparam int MEM_WORDS     = 256;
    // three cycles per instruction plus reset, with 20 percent on top
    localparam int TIMEOUT_NS =
        (NUM_INSTR * 3 * CLK_PERIOD_NS + RESET_CYCLES * CLK_PERIOD_NS) * 12 / 10;

    logic  clock;
    logic  rst_n;
    word_t mem_rdata;
    addr_t mem_addr;
    word_t mem_wdata;
    logic  mem_we;
    logic  fetch;

    word_t mem [MEM_WORDS];

    // reference model state
    word_t                 m_regs [`CPU_NREGS];
    logic [`CPU_NREGS-1:0] m_flags;
    word_t                 m_mem [MEM_WORDS];
    addr_t                 m_pc;

    logic  store_pending;
    logic  store_seen;
    addr_t store_pc;
    addr_t exp_store_addr;
    word_t exp_store_data;

    // position inside the fetch, execute, update cycle
    int   cycle_in_instr;

    int   errors;
    int   n_instr;
    int   n_stores;
    int   n_taken;
    logic run_done;

    cpu_top UUT
    (
        .clock     (clock),
        .rst_n     (rst_n),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .fetch     (fetch)
    );

    initial clock = 1'b0;
    always #(CLK_PERIOD_NS / 2) clock = ~clock;

    // memory answers reads at once, writes land on the rising edge
    assign mem_rdata = mem[mem_addr[7:0]];

    always @(posedge clock)
    begin
        if (mem_we)
            mem[mem_addr[7:0]] <= mem_wdata;
    end

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp)
        begin
            errors++;
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
        begin
            errors++;
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            errors++;
            $display("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    function automatic word_t encode(input opcode_t op, input reg_idx_t a, input reg_idx_t b,
                                     input reg_idx_t d, input logic half, input imm_t imm);
        return {imm, half, d, b, a, op};
    endfunction

    function automatic word_t random_instr();
        int unsigned pick;
        opcode_t     op;
        imm_t        imm;
        pick = $urandom % 14;
        if (pick < 9)
            op = opcode_t'(pick + 1);
        else if (pick < 11)
            op = `CPU_OP_BRF;
        else if (pick == 11)
            op = 6'd0;
        else if (pick == 12)
            op = 6'd63;
        else
            op = opcode_t'(10 + $urandom % 53);
        imm = imm_t'($urandom);
        // branch targets stay inside the 256 words
        if (op == `CPU_OP_BRF)
            imm = imm_t'($urandom % MEM_WORDS);
        return encode(op, reg_idx_t'($urandom), reg_idx_t'($urandom), reg_idx_t'($urandom),
                      1'($urandom), imm);
    endfunction

    task automatic fill_memory();
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            mem[i] = random_instr();
        end
        // LOADI then STORE pairs, r2 holds the store address
        mem[0] = encode(`CPU_OP_LOADI, 3'd0, 3'd0, 3'd2, 1'b0, 16'h00f0);
        mem[1] = encode(`CPU_OP_LOADI, 3'd0, 3'd0, 3'd1, 1'b1, 16'ha5a5);
        mem[2] = encode(`CPU_OP_STORE, 3'd2, 3'd1, 3'd0, 1'b0, 16'h0000);
        mem[3] = encode(`CPU_OP_LOADI, 3'd0, 3'd0, 3'd1, 1'b0, 16'h1234);
        mem[4] = encode(`CPU_OP_STORE, 3'd2, 3'd1, 3'd0, 1'b0, 16'h0000);
        mem[5] = encode(`CPU_OP_LOADI, 3'd0, 3'd0, 3'd1, 1'b1, 16'h5a5a);
        mem[6] = encode(`CPU_OP_STORE, 3'd2, 3'd1, 3'd0, 1'b0, 16'h0000);
        // carry out of ADD steers a branch over two words
        mem[7] = encode(`CPU_OP_LOADI, 3'd0, 3'd0, 3'd3, 1'b1, 16'hffff);
        mem[8] = encode(`CPU_OP_ADD, 3'd3, 3'd3, 3'd4, 1'b0, 16'h0000);
        mem[9] = encode(`CPU_OP_BRF, 3'd4, 3'd0, 3'd0, 1'b0, 16'd12);
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            m_mem[i] = mem[i];
        end
        for (int r = 0; r < `CPU_NREGS; r++)
        begin
            m_regs[r] = '0;
        end
        m_flags = '0;
        m_pc    = addr_t'(`CPU_RESET_PC);
    endtask

    // one instruction of the reference model, taken from its own memory copy
    task automatic step_model();
        word_t    w;
        opcode_t  op;
        reg_idx_t a;
        reg_idx_t b;
        reg_idx_t d;
        logic     half;
        imm_t     imm;
        word_t    va;
        word_t    vb;
        word_t    res;
        addr_t    next_pc;
        w       = m_mem[m_pc[7:0]];
        op      = w[5:0];
        a       = w[8:6];
        b       = w[11:9];
        d       = w[14:12];
        half    = w[15];
        imm     = w[31:16];
        va      = m_regs[a];
        vb      = m_regs[b];
        next_pc = m_pc + 32'd1;
        case (op)
            `CPU_OP_ADD:
            begin
                res        = va + vb;
                m_regs[d]  = res;
                m_flags[d] = (res < va);
            end
            `CPU_OP_SUB:
            begin
                m_regs[d]  = va - vb;
                m_flags[d] = (va < vb);
            end
            `CPU_OP_AND, `CPU_OP_OR, `CPU_OP_XOR:
            begin
                if (op == `CPU_OP_AND)
                    res = va & vb;
                else if (op == `CPU_OP_OR)
                    res = va | vb;
                else
                    res = va ^ vb;
                m_regs[d]  = res;
                m_flags[d] = (res == 32'd0);
            end
            `CPU_OP_LOADI:
            begin
                if (half)
                    m_regs[d][31:16] = imm;
                else
                    m_regs[d][15:0] = imm;
                m_flags[d] = 1'b0;
            end
            `CPU_OP_CMP:
                m_flags[d] = (va < vb);
            `CPU_OP_STORE:
            begin
                store_pending      = 1'b1;
                store_pc           = m_pc;
                exp_store_addr     = va;
                exp_store_data     = vb;
                m_mem[va[7:0]]     = vb;
                n_stores++;
            end
            `CPU_OP_BRF:
            begin
                if (m_flags[a])
                begin
                    next_pc = {16'h0000, imm};
                    n_taken++;
                end
            end
            default:
            begin
            end
        endcase
        m_pc = next_pc;
    endtask

    task automatic record_store();
        if (!store_pending || store_seen)
        begin
            errors++;
            $display("%0t: write strobe on mem_we with no STORE outstanding", $time);
        end
        else
        begin
            store_seen = 1'b1;
            check_addr("mem_addr", exp_store_addr, mem_addr);
            check_word("mem_wdata", exp_store_data, mem_wdata);
        end
    endtask

    task automatic close_instruction();
        if (store_pending && !store_seen)
        begin
            errors++;
            $display("%0t: STORE at pc %h gave no write strobe", $time, store_pc);
        end
        store_pending = 1'b0;
        store_seen    = 1'b0;
    endtask

    // outputs are sampled mid cycle, away from the rising edge
    always @(negedge clock)
    begin
        if (!rst_n)
        begin
            check_bit("mem_we", 1'b0, mem_we);
            check_bit("fetch", 1'b1, fetch);
            cycle_in_instr = 0;
        end
        else if (!run_done)
        begin
            // fetch comes back every third cycle
            check_bit("fetch", cycle_in_instr == 0, fetch);
            cycle_in_instr = (cycle_in_instr == 2) ? 0 : cycle_in_instr + 1;
            if (mem_we)
                record_store();
            if (fetch)
            begin
                close_instruction();
                if (n_instr == NUM_INSTR)
                begin
                    run_done = 1'b1;
                end
                else
                begin
                    check_addr("mem_addr", m_pc, mem_addr);
                    step_model();
                    n_instr++;
                end
            end
        end
    end

    initial
    begin
        void'($urandom(32'hc842bb26));
        rst_n          = 1'b0;
        errors         = 0;
        n_instr        = 0;
        n_stores       = 0;
        n_taken        = 0;
        run_done       = 1'b0;
        store_pending  = 1'b0;
        store_seen     = 1'b0;
        cycle_in_instr = 0;
        fill_memory();
        repeat (RESET_CYCLES) @(posedge clock);
        rst_n <= 1'b1;
        wait (run_done);
        $display("tb_cpu: %0d instructions, %0d stores, %0d branches taken, %0d errors",
                 n_instr, n_stores, n_taken, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("watchdog: no result reached after %0d ns, %0d instructions done",
                 TIMEOUT_NS, n_instr);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
